// File: design/fpuPkg.sv
package fpuPkg;

    localparam int SQN_W        = 7;    // micro-op sequence number width
    localparam int TAG_W        = 7;    // destination register tag width
    localparam int MANT_W       = 24;   // mantissa incl. hidden bit
    localparam int EXP_BIAS     = 127;
    localparam int CORE_STEPS   = 26;   // 24 result bits + guard + normalization
    localparam int UNIT_LATENCY = CORE_STEPS + 2;   // accept edge to result valid

    // default NaN for every invalid result
    localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

    typedef enum logic [1:0] {
        CLS_ZERO,       // zero or subnormal
        CLS_NORMAL,
        CLS_INF,
        CLS_NAN
    } fpClass;

    typedef enum logic {
        OP_DIV,
        OP_SQRT
    } divOp;

    // micro-op from the issue stage
    typedef struct packed {
        logic              valid;
        divOp              op;
        logic [31:0]       srcA;
        logic [31:0]       srcB;     // unused for sqrt
        logic [TAG_W-1:0]  tagDst;
        logic [SQN_W-1:0]  sqN;
        logic [31:0]       pc;
    } issueUop;

    // branch resolution, flushes younger micro-ops when taken
    typedef struct packed {
        logic              taken;
        logic [SQN_W-1:0]  sqN;
    } branchProv;

    // micro-op towards writeback
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tagDst;
        logic [SQN_W-1:0]  sqN;
        logic [31:0]       pc;
        logic [31:0]       result;
        logic [4:0]        flags;    // NV DZ OF UF NX
    } resultUop;

    typedef struct packed {
        logic              sign;
        fpClass            cls;
        logic signed [9:0] exp;      // unbiased
        logic [MANT_W-1:0] mant;     // 1.f for normals, else zero
    } unpackedFp;

    // raw recurrence output before rounding
    typedef struct packed {
        logic                  sign;
        logic signed [9:0]     exp;
        logic [CORE_STEPS-1:0] mant;    // leading one at msb or one below
        logic                  sticky;  // remainder nonzero
        divOp                  op;
        fpClass                clsA;
        fpClass                clsB;
    } coreResult;

endpackage

// File: design/fpUnpack.sv
`timescale 1ns/1ns

module fpUnpack import fpuPkg::*; (
    input  logic [31:0] in,
    output unpackedFp   out
);

    logic [7:0]  expField;
    logic [22:0] fracField;

    assign expField  = in[30:23];
    assign fracField = in[22:0];

    always_comb begin
        out.sign = in[31];
        out.cls  = CLS_NORMAL;
        out.exp  = '0;
        out.mant = '0;

        if (expField == 8'd0) begin
            out.cls = CLS_ZERO;     // subnormals flushed to zero
        end else if (expField == 8'hFF) begin
            if (fracField == '0) begin
                out.cls = CLS_INF;
            end else begin
                out.cls = CLS_NAN;  // quiet or signalling alike
            end
        end else begin
            out.exp  = {2'b00, expField} - 10'(EXP_BIAS);   // remove bias
            out.mant = {1'b1, fracField};                   // restore hidden bit
        end
    end

endmodule

// File: design/fpDivSqrtCore.sv
`timescale 1ns/1ns

module fpDivSqrtCore import fpuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      abort,
    input  divOp      op,
    input  unpackedFp a,
    input  unpackedFp b,
    output logic      done,
    output coreResult res
);

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_RUN,
        CORE_DONE
    } coreState;

    coreState state;
    logic [4:0] stepCnt;

    // recurrence registers
    logic [27:0]           rem;        // partial remainder, shared by both ops
    logic [CORE_STEPS-1:0] quo;        // quotient or root digits
    logic [MANT_W-1:0]     divisor;
    logic [51:0]           radicand;   // sqrt operand, consumed two bits per step

    // operand info kept for rounding
    divOp              opReg;
    logic              signReg;
    logic signed [9:0] expReg;
    fpClass            clsAReg;
    fpClass            clsBReg;

    logic [27:0] divTrial;
    logic        divFits;
    logic [27:0] sqrtRem;
    logic [27:0] sqrtTrial;
    logic        sqrtFits;

    logic              sqrtOdd;
    logic [MANT_W:0]   sqrtMant;
    logic signed [9:0] sqrtExpEven;

    // divide step: subtract divisor when it fits
    assign divTrial = rem - {4'b0, divisor};
    assign divFits  = rem >= {4'b0, divisor};

    // sqrt step: bring down next pair, trial is 4q+1
    assign sqrtRem   = {rem[25:0], radicand[51:50]};
    assign sqrtTrial = {quo, 2'b01};
    assign sqrtFits  = sqrtRem >= sqrtTrial;

    // odd exponent: double the mantissa so the exponent halves exactly
    assign sqrtOdd     = a.exp[0];
    assign sqrtMant    = sqrtOdd ? {a.mant, 1'b0} : {1'b0, a.mant};
    assign sqrtExpEven = a.exp - {9'b0, sqrtOdd};

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state   <= CORE_IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        state   <= CORE_RUN;
                        stepCnt <= '0;
                    end
                end
                CORE_RUN: begin
                    stepCnt <= stepCnt + 5'd1;
                    if (stepCnt == 5'(CORE_STEPS - 1)) begin
                        state <= CORE_DONE;
                    end
                end
                default: begin
                    state <= CORE_IDLE;     // done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && start) begin
            opReg   <= op;
            clsAReg <= a.cls;
            clsBReg <= b.cls;
            quo     <= '0;
            if (op == OP_DIV) begin
                signReg  <= a.sign ^ b.sign;
                expReg   <= a.exp - b.exp;
                rem      <= {4'b0, a.mant};
                divisor  <= b.mant;
                radicand <= '0;
            end else begin
                signReg  <= a.sign;
                expReg   <= sqrtExpEven >>> 1;
                rem      <= '0;
                divisor  <= '0;
                radicand <= {sqrtMant, 27'b0};  // root lands with msb at bit 25
            end
        end else if (state == CORE_RUN) begin
            if (opReg == OP_DIV) begin
                quo <= {quo[CORE_STEPS-2:0], divFits};
                rem <= divFits ? {divTrial[26:0], 1'b0} : {rem[26:0], 1'b0};
            end else begin
                quo      <= {quo[CORE_STEPS-2:0], sqrtFits};
                rem      <= sqrtFits ? sqrtRem - sqrtTrial : sqrtRem;
                radicand <= {radicand[49:0], 2'b00};
            end
        end
    end

    assign done = (state == CORE_DONE);

    assign res = '{
        sign:   signReg,
        exp:    expReg,
        mant:   quo,
        sticky: (rem != '0),
        op:     opReg,
        clsA:   clsAReg,
        clsB:   clsBReg
    };

endmodule

// File: design/fpRoundPack.sv
`timescale 1ns/1ns

module fpRoundPack import fpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        done,
    input  coreResult   in,
    output logic        valid,
    output logic [31:0] result,
    output logic [4:0]  flags
);

    logic              top;
    logic [MANT_W-1:0] mantN;
    logic              guard;
    logic              stickyN;
    logic signed [9:0] expN;
    logic              roundUp;
    logic [MANT_W:0]   mantSum;
    logic [MANT_W-1:0] mantR;
    logic signed [9:0] expBiased;
    logic              inexact;

    logic isDiv;
    logic invalid;
    logic divZero;
    logic infRes;
    logic zeroRes;

    logic [31:0] resNext;
    logic [4:0]  flagsNext;

    // one-place normalization
    assign top     = in.mant[CORE_STEPS-1];
    assign mantN   = top ? in.mant[25:2] : in.mant[24:1];
    assign guard   = top ? in.mant[1] : in.mant[0];
    assign stickyN = in.sticky | (top & in.mant[0]);
    assign expN    = top ? in.exp : in.exp - 10'sd1;

    // nearest even
    assign roundUp   = guard & (stickyN | mantN[0]);
    assign mantSum   = {1'b0, mantN} + {{MANT_W{1'b0}}, roundUp};
    assign mantR     = mantSum[MANT_W] ? mantSum[MANT_W:1] : mantSum[MANT_W-1:0];
    assign expBiased = expN + {9'b0, mantSum[MANT_W]} + 10'(EXP_BIAS);
    assign inexact   = guard | stickyN;

    assign isDiv = (in.op == OP_DIV);

    assign invalid = (in.clsA == CLS_NAN)
                   || (isDiv && in.clsB == CLS_NAN)
                   || (isDiv && in.clsA == CLS_ZERO && in.clsB == CLS_ZERO)
                   || (isDiv && in.clsA == CLS_INF && in.clsB == CLS_INF)
                   || (!isDiv && in.sign && in.clsA != CLS_ZERO);   // sqrt of negative

    assign divZero = isDiv && in.clsA == CLS_NORMAL && in.clsB == CLS_ZERO;
    assign infRes  = (in.clsA == CLS_INF);      // inf/finite or sqrt(+inf)
    assign zeroRes = (in.clsA == CLS_ZERO) || (isDiv && in.clsB == CLS_INF);

    // flags are {NV, DZ, OF, UF, NX}
    always_comb begin
        resNext   = {in.sign, expBiased[7:0], mantR[MANT_W-2:0]};
        flagsNext = {4'b0000, inexact};
        if (invalid) begin
            resNext   = CANON_NAN;
            flagsNext = 5'b10000;
        end else if (divZero) begin
            resNext   = {in.sign, 8'hFF, 23'b0};
            flagsNext = 5'b01000;
        end else if (infRes) begin
            resNext   = {in.sign, 8'hFF, 23'b0};
            flagsNext = 5'b00000;
        end else if (zeroRes) begin
            resNext   = {in.sign, 31'b0};
            flagsNext = 5'b00000;
        end else if (expBiased > 10'sd254) begin
            resNext   = {in.sign, 8'hFF, 23'b0};     // overflow to infinity
            flagsNext = 5'b00101;
        end else if (expBiased < 10'sd1) begin
            resNext   = {in.sign, 31'b0};            // flush tiny results
            flagsNext = 5'b00011;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            result <= resNext;
            flags  <= flagsNext;
        end
    end

endmodule

// File: design/fpDivUnit.sv
`timescale 1ns/1ns

module fpDivUnit import fpuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  logic      wbAvail,
    output logic      busy,
    input  branchProv branch,
    input  issueUop   issue,
    output resultUop  result
);

    unpackedFp opA;
    unpackedFp opB;
    coreResult coreRes;
    logic      coreDone;

    logic        rpValid;
    logic [31:0] rpResult;
    logic [4:0]  rpFlags;

    logic running;      // op inside the recurrence or rounding
    logic resValid;     // result waiting for writeback

    // metadata of the op in flight
    logic [TAG_W-1:0] tagReg;
    logic [SQN_W-1:0] sqNReg;
    logic [31:0]      pcReg;

    logic issueFlushed;
    logic curFlushed;
    logic accept;

    // true when op s is younger than branch b
    function automatic logic isYounger(input logic [SQN_W-1:0] s,
                                       input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] diff;
        diff = s - b;
        return $signed(diff) > 0;
    endfunction

    assign issueFlushed = branch.taken && isYounger(issue.sqN, branch.sqN);
    assign curFlushed   = branch.taken && isYounger(sqNReg, branch.sqN);

    assign accept = en && issue.valid && !running && !resValid && !issueFlushed;
    assign busy   = running || resValid || accept;

    fpUnpack unpackA (
        .in  (issue.srcA),
        .out (opA)
    );

    fpUnpack unpackB (
        .in  (issue.srcB),
        .out (opB)
    );

    fpDivSqrtCore core (
        .clk   (clk),
        .rst   (rst),
        .start (accept),
        .abort (running && curFlushed),
        .op    (issue.op),
        .a     (opA),
        .b     (opB),
        .done  (coreDone),
        .res   (coreRes)
    );

    fpRoundPack roundPack (
        .clk    (clk),
        .rst    (rst),
        .done   (coreDone),
        .in     (coreRes),
        .valid  (rpValid),
        .result (rpResult),
        .flags  (rpFlags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            resValid <= 1'b0;
        end else if (accept) begin
            running <= 1'b1;
        end else if (running) begin
            if (curFlushed) begin
                running <= 1'b0;    // dropped, no writeback
            end else if (rpValid) begin
                running  <= 1'b0;
                resValid <= 1'b1;
            end
        end else if (resValid && (wbAvail || curFlushed)) begin
            resValid <= 1'b0;       // consumed or flushed while held
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tagReg <= issue.tagDst;
            sqNReg <= issue.sqN;
            pcReg  <= issue.pc;
        end
    end

    // rounding output stays put until the next op completes
    assign result = '{
        valid:  resValid,
        tagDst: tagReg,
        sqN:    sqNReg,
        pc:     pcReg,
        result: rpResult,
        flags:  rpFlags
    };

endmodule

// File: testbench/fpDivTb.sv
`timescale 1ns/1ns

module fpDivTb import fpuPkg::*; ();

    logic      clk;
    logic      rst;
    logic      en;
    logic      wbAvail;
    logic      busy;
    branchProv branch;
    issueUop   issue;
    resultUop  result;

    // test table from the data file
    string       tName[$];
    divOp        tOp[$];
    logic [31:0] tA[$];
    logic [31:0] tB[$];
    logic [31:0] tRes[$];
    logic [4:0]  tFlags[$];
    int          tFlush[$];
    int          tStall[$];

    int               limitCycles = 0;
    logic [SQN_W-1:0] nextSqN;

    fpDivUnit dut_i (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .wbAvail (wbAvail),
        .busy    (busy),
        .branch  (branch),
        .issue   (issue),
        .result  (result)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    task automatic checkVal(input string test, input string what,
                            input logic [31:0] expV, input logic [31:0] actV);
        assert (expV === actV) else begin
            $display("[ERROR] test %s, %s: expected %h, actual %h", test, what, expV, actV);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          cnt;
        int          opInt;
        int          flushAt;
        int          stall;
        string       line;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  flags;
        fd = $fopen("testbench/fpDivTests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;   // comment or blank
            end
            cnt = $sscanf(line, "%s %d %h %h %h %b %d %d",
                          name, opInt, a, b, res, flags, flushAt, stall);
            if (cnt != 8) begin
                $display("malformed line in the test data file: %s", line);
                $display("CHECKS FAILED");
                $fatal(1);
            end
            tName.push_back(name);
            if (opInt == 0) begin
                tOp.push_back(OP_DIV);
            end else begin
                tOp.push_back(OP_SQRT);
            end
            tA.push_back(a);
            tB.push_back(b);
            tRes.push_back(res);
            tFlags.push_back(flags);
            tFlush.push_back(flushAt);
            tStall.push_back(stall);
        end
        $fclose(fd);
    endtask

    task automatic compareResult(input int i, input logic [TAG_W-1:0] tag,
                                 input logic [SQN_W-1:0] sqN, input logic [31:0] pc);
        checkVal(tName[i], "result", tRes[i], result.result);
        checkVal(tName[i], "flags", 32'(tFlags[i]), 32'(result.flags));
        checkVal(tName[i], "tagDst", 32'(tag), 32'(result.tagDst));
        checkVal(tName[i], "sqN", 32'(sqN), 32'(result.sqN));
        checkVal(tName[i], "pc", pc, result.pc);
    endtask

    task automatic runTest(input int i);
        int               n;
        int               gap;
        logic             finished;
        logic             flushOn;
        logic [TAG_W-1:0] tag;
        logic [SQN_W-1:0] sqN;
        logic [31:0]      pc;
        gap     = int'($urandom_range(3, 0));
        tag     = TAG_W'($urandom);
        pc      = $urandom;
        sqN     = nextSqN;
        flushOn = (tFlush[i] >= 0);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        issue <= '{valid: 1'b1, op: tOp[i], srcA: tA[i], srcB: tB[i],
                   tagDst: tag, sqN: sqN, pc: pc};
        @(negedge clk);
        checkVal(tName[i], "busy in accept cycle", 32'd1, 32'(busy));
        @(posedge clk);     // acceptance edge
        issue.valid <= 1'b0;
        n        = 0;
        finished = 1'b0;
        while (!finished) begin
            if (flushOn && n == tFlush[i]) begin
                branch <= '{taken: 1'b1, sqN: sqN - 1'b1};   // older branch, flushes us
            end else if (flushOn && n == tFlush[i] + 1) begin
                branch.taken <= 1'b0;
            end
            if (!flushOn && n == UNIT_LATENCY + tStall[i]) begin
                wbAvail <= 1'b1;
            end else if (!flushOn && n == UNIT_LATENCY + tStall[i] + 1) begin
                wbAvail <= 1'b0;
            end
            @(negedge clk);
            if (flushOn && n == tFlush[i] + 1) begin
                checkVal(tName[i], "busy after flush", 32'd0, 32'(busy));
                checkVal(tName[i], "valid after flush", 32'd0, 32'(result.valid));
                finished = 1'b1;
            end else if (n < UNIT_LATENCY) begin
                checkVal(tName[i], "valid while running", 32'd0, 32'(result.valid));
                checkVal(tName[i], "busy while running", 32'd1, 32'(busy));
            end else if (!flushOn && n == UNIT_LATENCY + tStall[i] + 1) begin
                checkVal(tName[i], "valid after writeback", 32'd0, 32'(result.valid));
                checkVal(tName[i], "busy after writeback", 32'd0, 32'(busy));
                finished = 1'b1;
            end else begin
                // held result, must stay unchanged
                checkVal(tName[i], "valid while held", 32'd1, 32'(result.valid));
                checkVal(tName[i], "busy while held", 32'd1, 32'(busy));
                compareResult(i, tag, sqN, pc);
            end
            if (!finished) begin
                @(posedge clk);
                n++;
            end
        end
        nextSqN = nextSqN + 1'b1;
    endtask

    initial begin
        int seedDummy;
        int maxWait;
        seedDummy = $urandom(32'hf3ba_2078);
        rst       = 1'b1;
        en        = 1'b0;
        wbAvail   = 1'b0;
        branch    = '0;
        issue     = '0;
        nextSqN   = '0;
        loadTests();
        maxWait = 0;
        foreach (tStall[i]) begin
            if (tStall[i] > maxWait) maxWait = tStall[i];
            if (tFlush[i] > maxWait) maxWait = tFlush[i];
        end
        limitCycles = tName.size() * (UNIT_LATENCY + maxWait + 10) + 20;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        en  <= 1'b1;
        foreach (tName[i]) begin
            runTest(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limitCycles);
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

// File: testbench/fpDivTests.txt
# name op(0 div, 1 sqrt) srcA srcB expResult expFlags(NV DZ OF UF NX) flushAt stallCycles
# flushAt -1 means no flush, srcB is ignored for sqrt
div_exact        0 40C00000 40000000 40400000 00000 -1 0
div_one_third    0 3F800000 40400000 3EAAAAAB 00001 -1 0
div_five_thirds  0 40A00000 40400000 3FD55555 00001 -1 1
div_tenth        0 3F800000 41200000 3DCCCCCD 00001 -1 0
div_one_seventh  0 3F800000 40E00000 3E124925 00001 -1 0
div_neg_exact    0 C0F00000 40200000 C0400000 00000 -1 0
div_frac_exact   0 3F400000 3F000000 3FC00000 00000 -1 2
sqrt_four        1 40800000 00000000 40000000 00000 -1 0
sqrt_nine        1 41100000 00000000 40400000 00000 -1 0
sqrt_quarter     1 3E800000 00000000 3F000000 00000 -1 0
sqrt_two         1 40000000 00000000 3FB504F3 00001 -1 0
sqrt_half        1 3F000000 00000000 3F3504F3 00001 -1 0
sqrt_three       1 40400000 00000000 3FDDB3D7 00001 -1 0
sqrt_odd_exact   1 40100000 00000000 3FC00000 00000 -1 0
div_zero_zero    0 00000000 00000000 7FC00000 10000 -1 0
div_inf_inf      0 7F800000 FF800000 7FC00000 10000 -1 0
div_nan          0 7F800001 3F800000 7FC00000 10000 -1 0
div_by_zero      0 3F800000 80000000 FF800000 01000 -1 0
div_inf_num      0 FF800000 40000000 FF800000 00000 -1 0
div_zero_num     0 80000000 40A00000 80000000 00000 -1 0
div_num_inf      0 40400000 7F800000 00000000 00000 -1 0
div_subnormal    0 00000001 3F800000 00000000 00000 -1 0
sqrt_neg         1 C0800000 00000000 7FC00000 10000 -1 0
sqrt_neg_inf     1 FF800000 00000000 7FC00000 10000 -1 0
sqrt_pos_inf     1 7F800000 00000000 7F800000 00000 -1 0
sqrt_neg_zero    1 80000000 00000000 80000000 00000 -1 0
div_overflow     0 7F000000 3E800000 7F800000 00101 -1 0
div_underflow    0 00800000 40000000 00000000 00011 -1 0
div_neg_tiny     0 80800000 40000000 80000000 00011 -1 0
stall_long       0 40C00000 40000000 40400000 00000 -1 6
flush_running    0 3F800000 40400000 00000000 00000 5 0
flush_late       1 40800000 00000000 40000000 00000 27 0
flush_held       0 40C00000 40000000 40400000 00000 31 8
after_flush      0 40A00000 40400000 3FD55555 00001 -1 0

// File: flist.f
design/fpuPkg.sv
design/fpUnpack.sv
design/fpDivSqrtCore.sv
design/fpRoundPack.sv
design/fpDivUnit.sv
testbench/fpDivTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module fpDivTb -f flist.f -o fpDivSim
out=$(./obj_dir/fpDivSim)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "simulation did not report success"
exit 1
